// ==== rtl/ocm_pkg.sv ====
`default_nettype none

package ocm_pkg;

   // ------------------------------------------------------------
   // default sizes, overridden from the top level
   // ------------------------------------------------------------

   // output VCs per port
   localparam int default_num_vcs = 4;

   // router ports, including the local one
   localparam int default_num_ports = 5;

   // downstream buffer in flits, split evenly over the VCs
   localparam int default_buffer_size = 32;

   // flit payload width
   localparam int default_flit_data_width = 64;

   // ------------------------------------------------------------
   // internal error vector layout
   // ------------------------------------------------------------

   // switch grant that no allocated output VC owns
   localparam int err_unmatched = 0;
   // switch grant owned by more than one output VC
   localparam int err_multimatch = 1;
   // flit sent on a VC without credits
   localparam int err_credit_underflow = 2;
   // credit returned to a VC that already holds all of them
   localparam int err_credit_overflow = 3;

   localparam int num_error_bits = 4;

endpackage

`default_nettype wire

// ==== rtl/credit_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module credit_decode
   import ocm_pkg::*;
#(
   parameter int num_vcs = default_num_vcs,
   localparam int vc_idx_width = (num_vcs > 1) ? $clog2(num_vcs) : 1
)
(
   input  wire                     clk,
   input  wire                     rst_n,

   // credit strobe and VC index from the downstream router
   input  wire                     credit_valid,
   input  wire  [vc_idx_width-1:0] credit_vc,

   output logic                    fc_event_valid,
   output logic [0:num_vcs-1]      fc_event_sel_ovc
);

   logic                    credit_valid_q;
   logic [vc_idx_width-1:0] credit_vc_q;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         credit_valid_q <= 1'b0;
      else
         credit_valid_q <= credit_valid;
   end

   // index only changes when a credit actually arrives
   always_ff @(posedge clk)
   begin
      if (credit_valid)
         credit_vc_q <= credit_vc;
   end

   assign fc_event_valid = credit_valid_q;

   // one-hot VC mask, empty when no credit is pending
   always_comb
   begin
      fc_event_sel_ovc = '0;
      for (int v = 0; v < num_vcs; v++)
         fc_event_sel_ovc[v] = credit_valid_q && (credit_vc_q == vc_idx_width'(v));
   end

endmodule

`default_nettype wire

// ==== rtl/flit_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module flit_stage
   import ocm_pkg::*;
#(
   parameter int num_vcs   = default_num_vcs,
   parameter int num_ports = default_num_ports
)
(
   input  wire                   clk,
   input  wire                   rst_n,

   // switch allocator result for this output
   input  wire                   sw_gnt,
   input  wire  [0:num_ports-1]  sw_sel_ip,
   input  wire  [0:num_vcs-1]    sw_sel_ivc,
   input  wire                   flit_head,
   input  wire                   flit_tail,

   output logic                  flit_valid_q,
   output logic [0:num_ports-1]  sel_ip_q,
   output logic [0:num_vcs-1]    sel_ivc_q,
   output logic                  head_q,
   output logic                  tail_q
);

   // grant strobe, one cycle ahead of the channel register
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         flit_valid_q <= 1'b0;
      else
         flit_valid_q <= sw_gnt;
   end

   // ------------------------------------------------------------
   // flit in flight
   // ------------------------------------------------------------

   // winning port and VC are held until the next grant
   always_ff @(posedge clk)
   begin
      if (sw_gnt)
      begin
         sel_ip_q  <= sw_sel_ip;
         sel_ivc_q <= sw_sel_ivc;
         head_q    <= flit_head;
         tail_q    <= flit_tail;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/ovc_alloc_state.sv ====
`timescale 1ns/100ps
`default_nettype none

module ovc_alloc_state
   import ocm_pkg::*;
#(
   parameter int num_vcs   = default_num_vcs,
   parameter int num_ports = default_num_ports
)
(
   input  wire                           clk,
   input  wire                           rst_n,

   // VC allocator result, one owner slot per output VC
   input  wire  [0:num_vcs-1]            vc_gnt_ovc,
   input  wire  [0:num_vcs*num_ports-1]  vc_sel_ovc_ip,
   input  wire  [0:num_vcs*num_vcs-1]    vc_sel_ovc_ivc,

   // staged switch grant
   input  wire                           flit_valid_q,
   input  wire  [0:num_ports-1]          sel_ip_q,
   input  wire  [0:num_vcs-1]            sel_ivc_q,
   input  wire                           tail_q,

   output logic [0:num_vcs-1]            flit_sel_ovc,
   output logic [0:num_vcs-1]            elig_ovc,
   output logic                          error_unmatched,
   output logic                          error_multimatch
);

   logic [0:num_ports-1] owner_ip_q  [num_vcs];
   logic [0:num_vcs-1]   owner_ivc_q [num_vcs];
   logic [0:num_vcs-1]   allocated_q;
   logic [0:num_vcs-1]   match_ovc;
   logic [0:num_vcs-1]   release_ovc;

   // ------------------------------------------------------------
   // owner registers
   // ------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      for (int v = 0; v < num_vcs; v++)
      begin
         if (vc_gnt_ovc[v])
         begin
            owner_ip_q[v]  <= vc_sel_ovc_ip[v*num_ports +: num_ports];
            owner_ivc_q[v] <= vc_sel_ovc_ivc[v*num_vcs +: num_vcs];
         end
      end
   end

   // a new grant wins over a tail leaving in the same cycle
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         allocated_q <= '0;
      else
      begin
         for (int v = 0; v < num_vcs; v++)
         begin
            if (vc_gnt_ovc[v])
               allocated_q[v] <= 1'b1;
            else if (release_ovc[v])
               allocated_q[v] <= 1'b0;
         end
      end
   end

   // ------------------------------------------------------------
   // switch grant matching
   // ------------------------------------------------------------

   always_comb
   begin
      for (int v = 0; v < num_vcs; v++)
         match_ovc[v] = allocated_q[v] &&
                        (owner_ip_q[v] == sel_ip_q) &&
                        (owner_ivc_q[v] == sel_ivc_q);
   end

   // tail of the packet frees the VC for the allocator again
   assign release_ovc = match_ovc & {num_vcs{flit_valid_q & tail_q}};

   assign flit_sel_ovc = match_ovc;
   assign elig_ovc     = ~allocated_q;

   assign error_unmatched  = flit_valid_q && (match_ovc == '0);
   // more than one bit set in the match vector
   assign error_multimatch = flit_valid_q && ((match_ovc & (match_ovc - 1'b1)) != '0);

endmodule

`default_nettype wire

// ==== rtl/ovc_credit_tracker.sv ====
`timescale 1ns/100ps
`default_nettype none

module ovc_credit_tracker
   import ocm_pkg::*;
#(
   parameter int num_vcs     = default_num_vcs,
   parameter int buffer_size = default_buffer_size,
   localparam int max_credits = buffer_size / num_vcs,
   localparam int cnt_width   = $clog2(max_credits + 1)
)
(
   input  wire                clk,
   input  wire                rst_n,

   // flit leaving on the selected VC
   input  wire                flit_valid_q,
   input  wire  [0:num_vcs-1] flit_sel_ovc,

   // registered credit return
   input  wire                fc_event_valid,
   input  wire  [0:num_vcs-1] fc_event_sel_ovc,

   output logic [0:num_vcs-1] full_ovc,
   output logic [0:num_vcs-1] almost_full_ovc,
   output logic               error_underflow,
   output logic               error_overflow
);

   logic [cnt_width-1:0] count_q [num_vcs];
   logic [0:num_vcs-1]   sent_ovc;
   logic [0:num_vcs-1]   cred_ovc;
   logic [0:num_vcs-1]   underflow_ovc;
   logic [0:num_vcs-1]   overflow_ovc;

   assign sent_ovc = flit_sel_ovc & {num_vcs{flit_valid_q}};
   assign cred_ovc = fc_event_sel_ovc & {num_vcs{fc_event_valid}};

   // ------------------------------------------------------------
   // credit counters
   // ------------------------------------------------------------

   // flit and credit on the same VC cancel out
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int v = 0; v < num_vcs; v++)
            count_q[v] <= cnt_width'(max_credits);
      end
      else
      begin
         for (int v = 0; v < num_vcs; v++)
         begin
            if (sent_ovc[v] && !cred_ovc[v] && !underflow_ovc[v])
               count_q[v] <= count_q[v] - 1'b1;
            else if (cred_ovc[v] && !sent_ovc[v] && !overflow_ovc[v])
               count_q[v] <= count_q[v] + 1'b1;
         end
      end
   end

   // ------------------------------------------------------------
   // status and error flags
   // ------------------------------------------------------------

   always_comb
   begin
      for (int v = 0; v < num_vcs; v++)
      begin
         full_ovc[v]        = (count_q[v] == '0);
         almost_full_ovc[v] = (count_q[v] == cnt_width'(1));
         underflow_ovc[v]   = sent_ovc[v] && !cred_ovc[v] && (count_q[v] == '0);
         // counter saturates at the top
         overflow_ovc[v]    = cred_ovc[v] && !sent_ovc[v] &&
                              (count_q[v] == cnt_width'(max_credits));
      end
   end

   assign error_underflow = |underflow_ovc;
   assign error_overflow  = |overflow_ovc;

endmodule

`default_nettype wire

// ==== rtl/channel_output.sv ====
`timescale 1ns/100ps
`default_nettype none

module channel_output
   import ocm_pkg::*;
#(
   parameter int num_vcs         = default_num_vcs,
   parameter int flit_data_width = default_flit_data_width,
   localparam int vc_idx_width   = (num_vcs > 1) ? $clog2(num_vcs) : 1
)
(
   input  wire                          clk,
   input  wire                          rst_n,

   input  wire                          flit_valid_q,
   input  wire  [0:num_vcs-1]           flit_sel_ovc,
   input  wire                          head_q,
   input  wire                          tail_q,
   input  wire  [0:flit_data_width-1]   flit_data,
   input  wire  [0:num_error_bits-1]    errors,

   // outgoing flit channel
   output logic                         channel_valid,
   output logic                         channel_head,
   output logic                         channel_tail,
   output logic [vc_idx_width-1:0]      channel_vc,
   output logic [0:flit_data_width-1]   channel_data,

   output logic                         error
);

   logic                    flit_sent;
   logic [vc_idx_width-1:0] sel_idx;

   // one-hot to binary, OR of the indices of all set bits
   always_comb
   begin
      sel_idx = '0;
      for (int v = 0; v < num_vcs; v++)
         if (flit_sel_ovc[v])
            sel_idx = sel_idx | vc_idx_width'(v);
   end

   // unmatched grants never reach the link
   assign flit_sent = flit_valid_q && (flit_sel_ovc != '0);

   // ------------------------------------------------------------
   // channel register
   // ------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         channel_valid <= 1'b0;
      else
         channel_valid <= flit_sent;
   end

   always_ff @(posedge clk)
   begin
      if (flit_sent)
      begin
         channel_head <= head_q;
         channel_tail <= tail_q;
         channel_vc   <= sel_idx;
         channel_data <= flit_data;
      end
   end

   // error summary, no hold
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         error <= 1'b0;
      else
         error <= |errors;
   end

endmodule

`default_nettype wire

// ==== rtl/op_ctrl_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module op_ctrl_top
   import ocm_pkg::*;
#(
   parameter int num_vcs         = default_num_vcs,
   parameter int num_ports       = default_num_ports,
   parameter int buffer_size     = default_buffer_size,
   parameter int flit_data_width = default_flit_data_width,
   localparam int vc_idx_width   = (num_vcs > 1) ? $clog2(num_vcs) : 1
)
(
   input  wire                           clk,
   input  wire                           rst_n,

   input  wire                           credit_valid,
   input  wire  [vc_idx_width-1:0]       credit_vc,

   input  wire  [0:num_vcs-1]            vc_gnt_ovc,
   input  wire  [0:num_vcs*num_ports-1]  vc_sel_ovc_ip,
   input  wire  [0:num_vcs*num_vcs-1]    vc_sel_ovc_ivc,

   input  wire                           sw_gnt,
   input  wire  [0:num_ports-1]          sw_sel_ip,
   input  wire  [0:num_vcs-1]            sw_sel_ivc,
   input  wire                           flit_head,
   input  wire                           flit_tail,
   input  wire  [0:flit_data_width-1]    flit_data,

   output logic                          channel_valid,
   output logic                          channel_head,
   output logic                          channel_tail,
   output logic [vc_idx_width-1:0]       channel_vc,
   output logic [0:flit_data_width-1]    channel_data,

   output logic [0:num_vcs-1]            full_ovc,
   output logic [0:num_vcs-1]            almost_full_ovc,
   output logic [0:num_vcs-1]            elig_ovc,
   output logic                          error
);

   logic                      fc_event_valid;
   logic [0:num_vcs-1]        fc_event_sel_ovc;
   logic                      flit_valid_q;
   logic [0:num_ports-1]      sel_ip_q;
   logic [0:num_vcs-1]        sel_ivc_q;
   logic                      head_q;
   logic                      tail_q;
   logic [0:num_vcs-1]        flit_sel_ovc;
   logic                      error_unmatched;
   logic                      error_multimatch;
   logic                      error_underflow;
   logic                      error_overflow;
   logic [0:num_error_bits-1] errors;

   // ------------------------------------------------------------
   // decode
   // ------------------------------------------------------------

   credit_decode #(.num_vcs(num_vcs)) u_credit_decode (
      .clk              (clk),
      .rst_n            (rst_n),
      .credit_valid     (credit_valid),
      .credit_vc        (credit_vc),
      .fc_event_valid   (fc_event_valid),
      .fc_event_sel_ovc (fc_event_sel_ovc)
   );

   flit_stage #(.num_vcs(num_vcs), .num_ports(num_ports)) u_flit_stage (
      .clk          (clk),
      .rst_n        (rst_n),
      .sw_gnt       (sw_gnt),
      .sw_sel_ip    (sw_sel_ip),
      .sw_sel_ivc   (sw_sel_ivc),
      .flit_head    (flit_head),
      .flit_tail    (flit_tail),
      .flit_valid_q (flit_valid_q),
      .sel_ip_q     (sel_ip_q),
      .sel_ivc_q    (sel_ivc_q),
      .head_q       (head_q),
      .tail_q       (tail_q)
   );

   // ------------------------------------------------------------
   // execute
   // ------------------------------------------------------------

   ovc_alloc_state #(.num_vcs(num_vcs), .num_ports(num_ports)) u_ovc_alloc_state (
      .clk              (clk),
      .rst_n            (rst_n),
      .vc_gnt_ovc       (vc_gnt_ovc),
      .vc_sel_ovc_ip    (vc_sel_ovc_ip),
      .vc_sel_ovc_ivc   (vc_sel_ovc_ivc),
      .flit_valid_q     (flit_valid_q),
      .sel_ip_q         (sel_ip_q),
      .sel_ivc_q        (sel_ivc_q),
      .tail_q           (tail_q),
      .flit_sel_ovc     (flit_sel_ovc),
      .elig_ovc         (elig_ovc),
      .error_unmatched  (error_unmatched),
      .error_multimatch (error_multimatch)
   );

   ovc_credit_tracker #(.num_vcs(num_vcs), .buffer_size(buffer_size)) u_ovc_credit_tracker (
      .clk              (clk),
      .rst_n            (rst_n),
      .flit_valid_q     (flit_valid_q),
      .flit_sel_ovc     (flit_sel_ovc),
      .fc_event_valid   (fc_event_valid),
      .fc_event_sel_ovc (fc_event_sel_ovc),
      .full_ovc         (full_ovc),
      .almost_full_ovc  (almost_full_ovc),
      .error_underflow  (error_underflow),
      .error_overflow   (error_overflow)
   );

   // ------------------------------------------------------------
   // result
   // ------------------------------------------------------------

   assign errors[err_unmatched]        = error_unmatched;
   assign errors[err_multimatch]       = error_multimatch;
   assign errors[err_credit_underflow] = error_underflow;
   assign errors[err_credit_overflow]  = error_overflow;

   channel_output #(
      .num_vcs         (num_vcs),
      .flit_data_width (flit_data_width)
   ) u_channel_output (
      .clk           (clk),
      .rst_n         (rst_n),
      .flit_valid_q  (flit_valid_q),
      .flit_sel_ovc  (flit_sel_ovc),
      .head_q        (head_q),
      .tail_q        (tail_q),
      .flit_data     (flit_data),
      .errors        (errors),
      .channel_valid (channel_valid),
      .channel_head  (channel_head),
      .channel_tail  (channel_tail),
      .channel_vc    (channel_vc),
      .channel_data  (channel_data),
      .error         (error)
   );

endmodule

`default_nettype wire

// ==== tb/op_ctrl_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module op_ctrl_tb
   import ocm_pkg::*;
();

   localparam int num_vcs         = default_num_vcs;
   localparam int num_ports       = default_num_ports;
   localparam int buffer_size     = default_buffer_size;
   localparam int flit_data_width = default_flit_data_width;
   localparam int vc_idx_width    = (num_vcs > 1) ? $clog2(num_vcs) : 1;
   localparam int max_credits     = buffer_size / num_vcs;
   localparam int max_rows        = 40;

   localparam logic [1:0] op_idle     = 2'd0;
   localparam logic [1:0] op_vc_grant = 2'd1;
   localparam logic [1:0] op_sw_grant = 2'd2;
   localparam logic [1:0] op_credit   = 2'd3;

   // the flit and error of a stimulus row show up two cycles later
   typedef struct packed {
      logic [1:0] op;
      logic [3:0] vc;
      logic [3:0] port;
      logic [3:0] ivc;
      logic       head;
      logic       tail;
      logic       exp_flit;
      logic       exp_err;
   } row_t;

   logic                          clk;
   logic                          rst_n;
   logic                          credit_valid;
   logic [vc_idx_width-1:0]       credit_vc;
   logic [0:num_vcs-1]            vc_gnt_ovc;
   logic [0:num_vcs*num_ports-1]  vc_sel_ovc_ip;
   logic [0:num_vcs*num_vcs-1]    vc_sel_ovc_ivc;
   logic                          sw_gnt;
   logic [0:num_ports-1]          sw_sel_ip;
   logic [0:num_vcs-1]            sw_sel_ivc;
   logic                          flit_head;
   logic                          flit_tail;
   logic [0:flit_data_width-1]    flit_data;
   logic                          channel_valid;
   logic                          channel_head;
   logic                          channel_tail;
   logic [vc_idx_width-1:0]       channel_vc;
   logic [0:flit_data_width-1]    channel_data;
   logic [0:num_vcs-1]            full_ovc;
   logic [0:num_vcs-1]            almost_full_ovc;
   logic [0:num_vcs-1]            elig_ovc;
   logic                          error;

   row_t                       rows [max_rows];
   int                         num_rows;
   logic [0:flit_data_width-1] data_hist [max_rows+4];
   integer                     seed;

   // ------------------------------------------------------------
   // reference model state
   // ------------------------------------------------------------

   logic [0:num_vcs-1]         alloc_m;
   int                         owner_port_m [num_vcs];
   int                         owner_ivc_m [num_vcs];
   int                         count_m [num_vcs];
   logic                       exp_head;
   logic                       exp_tail;
   logic [vc_idx_width-1:0]    exp_vc;
   logic [0:flit_data_width-1] exp_data;

   initial clk = 1'b0;
   always #10 clk = ~clk;

   op_ctrl_top #(
      .num_vcs         (num_vcs),
      .num_ports       (num_ports),
      .buffer_size     (buffer_size),
      .flit_data_width (flit_data_width)
   ) u_dut (
      .clk             (clk),
      .rst_n           (rst_n),
      .credit_valid    (credit_valid),
      .credit_vc       (credit_vc),
      .vc_gnt_ovc      (vc_gnt_ovc),
      .vc_sel_ovc_ip   (vc_sel_ovc_ip),
      .vc_sel_ovc_ivc  (vc_sel_ovc_ivc),
      .sw_gnt          (sw_gnt),
      .sw_sel_ip       (sw_sel_ip),
      .sw_sel_ivc      (sw_sel_ivc),
      .flit_head       (flit_head),
      .flit_tail       (flit_tail),
      .flit_data       (flit_data),
      .channel_valid   (channel_valid),
      .channel_head    (channel_head),
      .channel_tail    (channel_tail),
      .channel_vc      (channel_vc),
      .channel_data    (channel_data),
      .full_ovc        (full_ovc),
      .almost_full_ovc (almost_full_ovc),
      .elig_ovc        (elig_ovc),
      .error           (error)
   );

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic report_mismatch(input string what, input logic [flit_data_width-1:0] got,
                                  input logic [flit_data_width-1:0] want);
      stop_run($sformatf("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, want));
   endtask

   task automatic check_channel(input logic want_valid, input logic want_head,
                                input logic want_tail, input logic [vc_idx_width-1:0] want_vc,
                                input logic [0:flit_data_width-1] want_data);
      if (channel_valid !== want_valid)
         report_mismatch("channel_valid", channel_valid, want_valid);
      if (want_valid)
      begin
         if (channel_head !== want_head)
            report_mismatch("channel_head", channel_head, want_head);
         if (channel_tail !== want_tail)
            report_mismatch("channel_tail", channel_tail, want_tail);
         if (channel_vc !== want_vc)
            report_mismatch("channel_vc", channel_vc, want_vc);
         if (channel_data !== want_data)
            report_mismatch("channel_data", channel_data, want_data);
      end
   endtask

   task automatic check_flags(input string what, input logic [0:num_vcs-1] got,
                              input logic [0:num_vcs-1] want);
      if (got !== want)
         report_mismatch(what, got, want);
   endtask

   task automatic check_error(input logic got, input logic want);
      if (got !== want)
         report_mismatch("error", got, want);
   endtask

   task automatic add_row(input logic [1:0] op, input logic [3:0] vc, input logic [3:0] port,
                          input logic [3:0] ivc, input logic head, input logic tail,
                          input logic exp_flit, input logic exp_err);
      if (num_rows == max_rows)
         stop_run("the stimulus table has more rows than it can hold");
      rows[num_rows] = {op, vc, port, ivc, head, tail, exp_flit, exp_err};
      num_rows++;
   endtask

   // ------------------------------------------------------------
   // stimulus table
   // ------------------------------------------------------------

   // row columns are op, vc, port, ivc, head, tail, expected flit and expected error
   task automatic build_table();
      num_rows = 0;
      add_row(op_idle,     0, 0, 0, 0, 0, 0, 0);
      add_row(op_vc_grant, 1, 2, 3, 0, 0, 0, 0);
      add_row(op_idle,     0, 0, 0, 0, 0, 0, 0);
      add_row(op_sw_grant, 0, 2, 3, 1, 0, 1, 0);
      // body flits until one credit is left
      for (int n = 0; n < max_credits - 2; n++)
         add_row(op_sw_grant, 0, 2, 3, 0, 0, 1, 0);
      add_row(op_idle,     0, 0, 0, 0, 0, 0, 0);
      // last credit used by the tail, which also frees the VC
      add_row(op_sw_grant, 0, 2, 3, 0, 1, 1, 0);
      add_row(op_idle,     0, 0, 0, 0, 0, 0, 0);
      add_row(op_idle,     0, 0, 0, 0, 0, 0, 0);
      add_row(op_credit,   1, 0, 0, 0, 0, 0, 0);
      add_row(op_credit,   1, 0, 0, 0, 0, 0, 0);
      add_row(op_credit,   1, 0, 0, 0, 0, 0, 0);
      add_row(op_vc_grant, 0, 4, 0, 0, 0, 0, 0);
      add_row(op_sw_grant, 0, 4, 0, 1, 1, 1, 0);
      add_row(op_idle,     0, 0, 0, 0, 0, 0, 0);
      // grant that no output VC owns
      add_row(op_sw_grant, 0, 0, 1, 1, 0, 0, 1);
      add_row(op_idle,     0, 0, 0, 0, 0, 0, 0);
      // credit to a VC that holds all of them
      add_row(op_credit,   3, 0, 0, 0, 0, 0, 1);
      add_row(op_idle,     0, 0, 0, 0, 0, 0, 0);
      add_row(op_vc_grant, 2, 1, 2, 0, 0, 0, 0);
      add_row(op_sw_grant, 0, 1, 2, 1, 0, 1, 0);
      add_row(op_sw_grant, 0, 1, 2, 0, 1, 1, 0);
      add_row(op_idle,     0, 0, 0, 0, 0, 0, 0);
   endtask

   task automatic drive_idle();
      credit_valid   = 1'b0;
      credit_vc      = '0;
      vc_gnt_ovc     = '0;
      vc_sel_ovc_ip  = '0;
      vc_sel_ovc_ivc = '0;
      sw_gnt         = 1'b0;
      sw_sel_ip      = '0;
      sw_sel_ivc     = '0;
      flit_head      = 1'b0;
      flit_tail      = 1'b0;
   endtask

   // rows past the end of the table drive idle cycles
   task automatic drive_row(input int i);
      row_t                 r;
      logic [0:num_ports-1] ip_oh;
      logic [0:num_vcs-1]   ivc_oh;
      r = (i < num_rows) ? rows[i] : '0;
      ip_oh = '0;
      ivc_oh = '0;
      ip_oh[r.port] = 1'b1;
      ivc_oh[r.ivc] = 1'b1;
      drive_idle();
      flit_data = {$random(seed), $random(seed)};
      data_hist[i] = flit_data;
      case (r.op)
         op_vc_grant:
         begin
            vc_gnt_ovc[r.vc] = 1'b1;
            vc_sel_ovc_ip[r.vc*num_ports +: num_ports] = ip_oh;
            vc_sel_ovc_ivc[r.vc*num_vcs +: num_vcs] = ivc_oh;
         end
         op_sw_grant:
         begin
            sw_gnt     = 1'b1;
            sw_sel_ip  = ip_oh;
            sw_sel_ivc = ivc_oh;
            flit_head  = r.head;
            flit_tail  = r.tail;
         end
         op_credit:
         begin
            credit_valid = 1'b1;
            credit_vc    = vc_idx_width'(r.vc);
         end
         default:
            drive_idle();
      endcase
   endtask

   task automatic init_model();
      alloc_m  = '0;
      exp_head = 1'b0;
      exp_tail = 1'b0;
      exp_vc   = '0;
      exp_data = '0;
      for (int v = 0; v < num_vcs; v++)
      begin
         owner_port_m[v] = 0;
         owner_ivc_m[v]  = 0;
         count_m[v]      = max_credits;
      end
   endtask

   // state after edge j holds the flits and credits of row j-2 and the VC grants of row j-1
   task automatic update_model(input int j);
      row_t r;
      if (j >= 2 && j - 2 < num_rows)
      begin
         r = rows[j-2];
         if (r.op == op_sw_grant)
         begin
            for (int v = 0; v < num_vcs; v++)
            begin
               if (alloc_m[v] && owner_port_m[v] == r.port && owner_ivc_m[v] == r.ivc)
               begin
                  exp_vc = vc_idx_width'(v);
                  if (count_m[v] > 0)
                     count_m[v]--;
                  if (r.tail)
                     alloc_m[v] = 1'b0;
               end
            end
            exp_head = r.head;
            exp_tail = r.tail;
            exp_data = data_hist[j-1];
         end
         else if (r.op == op_credit && count_m[r.vc] < max_credits)
            count_m[r.vc]++;
      end
      // a new grant wins over a release at the same edge
      if (j >= 1 && j - 1 < num_rows && rows[j-1].op == op_vc_grant)
      begin
         r = rows[j-1];
         owner_port_m[r.vc] = r.port;
         owner_ivc_m[r.vc]  = r.ivc;
         alloc_m[r.vc]      = 1'b1;
      end
   endtask

   task automatic check_state(input int j);
      logic [0:num_vcs-1] exp_full;
      logic [0:num_vcs-1] exp_almost;
      logic               exp_valid;
      logic               exp_err;
      exp_valid = 1'b0;
      exp_err   = 1'b0;
      if (j >= 2 && j - 2 < num_rows)
      begin
         exp_valid = rows[j-2].exp_flit;
         exp_err   = rows[j-2].exp_err;
      end
      for (int v = 0; v < num_vcs; v++)
      begin
         exp_full[v]   = (count_m[v] == 0);
         exp_almost[v] = (count_m[v] == 1);
      end
      check_channel(exp_valid, exp_head, exp_tail, exp_vc, exp_data);
      check_flags("elig_ovc", elig_ovc, ~alloc_m);
      check_flags("full_ovc", full_ovc, exp_full);
      check_flags("almost_full_ovc", almost_full_ovc, exp_almost);
      check_error(error, exp_err);
   endtask

   // ------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------

   initial
   begin
      seed      = 32'h00361f66;
      rst_n     = 1'b0;
      flit_data = '0;
      drive_idle();
      init_model();
      build_table();
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;
      // state right after reset
      check_state(0);
      for (int i = 0; i < num_rows + 2; i++)
      begin
         drive_row(i);
         @(posedge clk);
         #1;
         update_model(i + 1);
         check_state(i + 1);
      end
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/ocm_pkg.sv
rtl/credit_decode.sv
rtl/flit_stage.sv
rtl/ovc_alloc_state.sv
rtl/ovc_credit_tracker.sv
rtl/channel_output.sv
rtl/op_ctrl_top.sv
tb/op_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: op_ctrl

sources:
  - files:
      - rtl/ocm_pkg.sv
      - rtl/credit_decode.sv
      - rtl/flit_stage.sv
      - rtl/ovc_alloc_state.sv
      - rtl/ovc_credit_tracker.sv
      - rtl/channel_output.sv
      - rtl/op_ctrl_top.sv
  - target: simulation
    files:
      - tb/op_ctrl_tb.sv
